/* Bender.yml */
package:
  name: ntt_wrapper

sources:
  - src/ntt_params_pkg.sv
  - src/ntt_regs_pkg.sv
  - src/ntt_mem_if.sv
  - src/ntt_bus_slave.sv
  - src/ntt_bus_adapter.sv
  - src/ntt_coef_mem.sv
  - src/ntt_butterfly.sv
  - src/ntt_ctrl.sv
  - src/ntt_wrapper_top.sv
  - target: test
    files:
      - dv/ntt_tb.sv

/* dv/ntt_tb.sv */
//============================
// NTT wrapper testbench
// AHB-lite traffic, software reference transform, stimulus table
//============================
`timescale 1ns/1ps

module ntt_tb;

    localparam int          HADDR_WIDTH   = 8;
    localparam int          HDATA_WIDTH   = 32;
    localparam int          Q             = ntt_params_pkg::NTT_Q;
    localparam int          N             = ntt_params_pkg::NTT_N;
    localparam int          TABLE_LEN     = 7;
    localparam int          MAX_POLL      = 100;
    localparam logic [31:0] SEED          = 32'h70f8_40f1;
    localparam logic [1:0]  HTRANS_IDLE   = 2'b00;
    localparam logic [1:0]  HTRANS_NONSEQ = 2'b10;

    typedef ntt_params_pkg::coef_t coef_t;
    typedef int vec_t [N];

    // Up to two transforms per entry, vector source and busy probe
    typedef struct packed {
        logic [1:0]              n_ops;
        ntt_regs_pkg::ntt_mode_e op0;
        ntt_regs_pkg::ntt_mode_e op1;
        logic                    use_rand;
        logic [1:0]              pattern;
        logic                    probe;
    } test_case_t;

    // Fixed patterns: 0 ramp, 1 all q-1, 2 impulse
    localparam test_case_t TESTS [TABLE_LEN] = '{
        '{2'd1, ntt_regs_pkg::MODE_CT, ntt_regs_pkg::MODE_CT, 1'b0, 2'd0, 1'b0},
        '{2'd1, ntt_regs_pkg::MODE_CT, ntt_regs_pkg::MODE_CT, 1'b0, 2'd2, 1'b0},
        '{2'd1, ntt_regs_pkg::MODE_CT, ntt_regs_pkg::MODE_CT, 1'b1, 2'd0, 1'b0},
        '{2'd1, ntt_regs_pkg::MODE_GS, ntt_regs_pkg::MODE_GS, 1'b1, 2'd0, 1'b0},
        '{2'd1, ntt_regs_pkg::MODE_GS, ntt_regs_pkg::MODE_GS, 1'b1, 2'd0, 1'b1},
        '{2'd2, ntt_regs_pkg::MODE_CT, ntt_regs_pkg::MODE_GS, 1'b1, 2'd0, 1'b1},
        '{2'd2, ntt_regs_pkg::MODE_CT, ntt_regs_pkg::MODE_GS, 1'b0, 2'd1, 1'b0}
    };

    logic                   hclk;
    logic                   reset_i;
    logic [HADDR_WIDTH-1:0] haddr_i;
    logic [HDATA_WIDTH-1:0] hwdata_i;
    logic                   hsel_i;
    logic                   hwrite_i;
    logic                   hready_i;
    logic [1:0]             htrans_i;
    logic [HDATA_WIDTH-1:0] hrdata_o;
    logic                   hreadyout_o;
    logic                   hresp_o;

    ntt_wrapper_top #(.HADDR_WIDTH(HADDR_WIDTH), .HDATA_WIDTH(HDATA_WIDTH)) u_dut (
        .hclk(hclk), .reset_i(reset_i), .haddr_i(haddr_i), .hwdata_i(hwdata_i),
        .hsel_i(hsel_i), .hwrite_i(hwrite_i), .hready_i(hready_i), .htrans_i(htrans_i),
        .hrdata_o(hrdata_o), .hreadyout_o(hreadyout_o), .hresp_o(hresp_o)
    );

    initial hclk = 1'b0;
    always #50 hclk = ~hclk;

    //==============================
    // Failure reporting and checks
    //==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_coef(input string name, input coef_t got, input coef_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [HDATA_WIDTH-1:0] got,
                              input logic [HDATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    // Response bits are hresp in the first and in the last data-phase cycle
    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    //==============================
    // AHB-lite transfers
    //==============================
    task automatic bus_xfer(input logic wr, input logic [HADDR_WIDTH-1:0] addr,
                            input logic [HDATA_WIDTH-1:0] wdata, input logic exp_err,
                            output logic [HDATA_WIDTH-1:0] rdata, output logic [1:0] resp);
        int waits;
        int exp_waits;
        haddr_i  = addr;
        hwrite_i = wr;
        hsel_i   = 1'b1;
        htrans_i = HTRANS_NONSEQ;
        @(negedge hclk);
        hsel_i   = 1'b0;
        htrans_i = HTRANS_IDLE;
        hwdata_i = wdata;
        waits    = 0;
        resp[1]  = hresp_o;
        while (!hreadyout_o && waits < 4) begin
            waits++;
            @(negedge hclk);
        end
        resp[0]   = hresp_o;
        rdata     = hrdata_o;
        // Reads and errors take one wait state, good writes none
        exp_waits = (exp_err || !wr) ? 1 : 0;
        if (waits != exp_waits) begin
            abort_run($sformatf("Transfer to address 0x%02h took %0d wait states, not %0d",
                                addr, waits, exp_waits));
        end
        @(negedge hclk);
    endtask

    task automatic bus_write(input logic [HADDR_WIDTH-1:0] addr,
                             input logic [HDATA_WIDTH-1:0] data, input logic exp_err);
        logic [HDATA_WIDTH-1:0] unused;
        logic [1:0]             resp;
        bus_xfer(1'b1, addr, data, exp_err, unused, resp);
        check_resp($sformatf("hresp write 0x%02h", addr), resp, {2{exp_err}});
    endtask

    task automatic bus_read(input logic [HADDR_WIDTH-1:0] addr,
                            output logic [HDATA_WIDTH-1:0] data, input logic exp_err);
        logic [1:0] resp;
        bus_xfer(1'b0, addr, '0, exp_err, data, resp);
        check_resp($sformatf("hresp read 0x%02h", addr), resp, {2{exp_err}});
    endtask

    function automatic logic [HADDR_WIDTH-1:0] coef_addr(input int i);
        return HADDR_WIDTH'(ntt_regs_pkg::COEF_BASE + 4 * i);
    endfunction

    //==============================
    // Reference transform
    //==============================
    function automatic int mod_q(input int v);
        int r;
        r = v % Q;
        if (r < 0) r += Q;
        return r;
    endfunction

    // Forward walks len 8 down to 1 with k rising, inverse len 1 up to 8 with k falling
    function automatic vec_t model_transform(input vec_t x, input ntt_regs_pkg::ntt_mode_e mode);
        vec_t y;
        int   len;
        int   k;
        int   w;
        int   a;
        int   b;
        y   = x;
        k   = (mode == ntt_regs_pkg::MODE_CT) ? 1 : 15;
        len = (mode == ntt_regs_pkg::MODE_CT) ? 8 : 1;
        while (len >= 1 && len <= 8) begin
            for (int start = 0; start < N; start += 2 * len) begin
                if (mode == ntt_regs_pkg::MODE_CT) begin
                    w = int'(ntt_params_pkg::NTT_TWIDDLE[k]);
                    k++;
                end else begin
                    w = Q - int'(ntt_params_pkg::NTT_TWIDDLE[k]);
                    k--;
                end
                for (int j = start; j < start + len; j++) begin
                    a = y[j];
                    b = y[j + len];
                    if (mode == ntt_regs_pkg::MODE_CT) begin
                        y[j]       = mod_q(a + mod_q(w * b));
                        y[j + len] = mod_q(a - mod_q(w * b));
                    end else begin
                        y[j]       = mod_q(a + b);
                        y[j + len] = mod_q((a - b) * w);
                    end
                end
            end
            len = (mode == ntt_regs_pkg::MODE_CT) ? len / 2 : len * 2;
        end
        return y;
    endfunction

    function automatic vec_t make_vector(input test_case_t tc);
        vec_t v;
        for (int i = 0; i < N; i++) begin
            if (tc.use_rand) v[i] = int'($urandom % Q);
            else if (tc.pattern == 2'd0) v[i] = (17 * i + 3) % Q;
            else if (tc.pattern == 2'd1) v[i] = Q - 1;
            else v[i] = (i == 0) ? 1 : 0;
        end
        return v;
    endfunction

    //==============================
    // Engine control
    //==============================
    task automatic load_vector(input vec_t x);
        logic [HDATA_WIDTH-1:0] junk;
        for (int i = 0; i < N; i++) begin
            // Upper bits are ignored by the window
            junk = $urandom;
            bus_write(coef_addr(i), {junk[HDATA_WIDTH-1:9], 9'(x[i])}, 1'b0);
        end
    endtask

    task automatic wait_done();
        logic [HDATA_WIDTH-1:0] rd;
        int                     polls;
        polls = 0;
        rd    = '0;
        while (rd !== 32'h2 && polls < MAX_POLL) begin
            bus_read(8'(ntt_regs_pkg::REG_STATUS), rd, 1'b0);
            polls++;
        end
        if (rd !== 32'h2) begin
            abort_run("Transform did not finish within the polling limit");
        end
    endtask

    task automatic run_op(input ntt_regs_pkg::ntt_mode_e mode, input logic probe);
        logic [HDATA_WIDTH-1:0] rd;
        bus_write(8'(ntt_regs_pkg::REG_CTRL), 32'({mode, 1'b1}), 1'b0);
        // Start clears done and busy is already up
        bus_read(8'(ntt_regs_pkg::REG_STATUS), rd, 1'b0);
        check_word("STATUS after start", rd, 32'h1);
        bus_read(8'(ntt_regs_pkg::REG_CTRL), rd, 1'b0);
        check_word("CTRL mode", rd, 32'({mode, 1'b0}));
        if (probe) begin
            bus_write(coef_addr(5), 32'h0000_0055, 1'b1);
            bus_read(coef_addr(5), rd, 1'b1);
        end
        wait_done();
    endtask

    //==============================
    // Main sequence
    //==============================
    initial begin
        vec_t                    x;
        vec_t                    exp_v;
        test_case_t              tc;
        logic [HDATA_WIDTH-1:0]  rd;
        logic [HDATA_WIDTH-1:0]  wd;
        ntt_regs_pkg::ntt_mode_e op;
        void'($urandom(SEED));
        reset_i  = 1'b1;
        haddr_i  = '0;
        hwdata_i = '0;
        hsel_i   = 1'b0;
        hwrite_i = 1'b0;
        hready_i = 1'b1;
        htrans_i = HTRANS_IDLE;
        repeat (16) @(negedge hclk);
        reset_i = 1'b0;
        @(negedge hclk);

        // Window readback keeps the low 9 bits
        for (int i = 0; i < N; i++) begin
            wd = $urandom;
            bus_write(coef_addr(i), wd, 1'b0);
            bus_read(coef_addr(i), rd, 1'b0);
            check_word($sformatf("coef[%0d] readback", i), rd, HDATA_WIDTH'(wd[8:0]));
        end

        // Unmapped and misaligned addresses
        bus_read(8'h08, rd, 1'b1);
        bus_read(8'h80, rd, 1'b1);
        bus_read(8'h42, rd, 1'b1);
        bus_write(8'h3C, 32'h1234_5678, 1'b1);

        for (int c = 0; c < TABLE_LEN; c++) begin
            tc    = TESTS[c];
            x     = make_vector(tc);
            load_vector(x);
            exp_v = x;
            for (int n = 0; n < int'(tc.n_ops); n++) begin
                op = (n == 0) ? tc.op0 : tc.op1;
                run_op(op, tc.probe);
                exp_v = model_transform(exp_v, op);
            end
            for (int i = 0; i < N; i++) begin
                bus_read(coef_addr(i), rd, 1'b0);
                check_coef($sformatf("case %0d coef[%0d]", c, i), coef_t'(rd), coef_t'(exp_v[i]));
                if (tc.n_ops == 2'd2 && tc.op0 == ntt_regs_pkg::MODE_CT
                    && tc.op1 == ntt_regs_pkg::MODE_GS) begin
                    check_coef($sformatf("case %0d round trip coef[%0d]", c, i),
                               coef_t'(rd), coef_t'((16 * x[i]) % Q));
                end
            end
        end

        $display("Everything OK");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (TABLE_LEN * 2000 + 100) @(posedge hclk);
        abort_run("Watchdog expired before the tests finished");
    end

endmodule

/* files.f */
src/ntt_params_pkg.sv
src/ntt_regs_pkg.sv
src/ntt_mem_if.sv
src/ntt_bus_slave.sv
src/ntt_bus_adapter.sv
src/ntt_coef_mem.sv
src/ntt_butterfly.sv
src/ntt_ctrl.sv
src/ntt_wrapper_top.sv
dv/ntt_tb.sv

/* src/ntt_bus_adapter.sv */
//============================
// Bus adapter
// Decodes CTRL, STATUS and the coefficient window
//============================
`timescale 1ns/1ps

module ntt_bus_adapter #(
    parameter int HADDR_WIDTH = 8,
    parameter int HDATA_WIDTH = 32
) (
    input  logic                      hclk,
    input  logic                      reset_i,
    input  ntt_regs_pkg::bus_kind_e   kind_i,
    input  logic [HADDR_WIDTH-1:0]    addr_i,
    input  logic [HDATA_WIDTH-1:0]    wdata_i,
    input  logic                      busy_i,
    input  logic                      done_i,
    output logic [HDATA_WIDTH-1:0]    rdata_o,
    output logic                      err_o,
    output logic                      start_o,
    output ntt_regs_pkg::ntt_mode_e   mode_o,
    output logic                      mem_en_o,
    output logic                      mem_we_o,
    output ntt_params_pkg::coef_idx_t mem_addr_o,
    output ntt_params_pkg::coef_t     mem_wdata_o,
    input  ntt_params_pkg::coef_t     mem_rdata_i
);

    localparam int unsigned COEF_END = ntt_regs_pkg::COEF_BASE + 4 * ntt_params_pkg::NTT_N;

    typedef enum logic [1:0] {SEL_NONE, SEL_CTRL, SEL_STATUS, SEL_COEF} rd_sel_e;

    rd_sel_e                 rsel_q;
    ntt_regs_pkg::ntt_mode_e mode_q;
    logic                    req, wr;
    logic                    is_ctrl, is_status, is_coef;

    assign req = kind_i != ntt_regs_pkg::KIND_IDLE;
    assign wr  = kind_i == ntt_regs_pkg::KIND_WRITE;

    // Address decode
    assign is_ctrl   = addr_i == HADDR_WIDTH'(ntt_regs_pkg::REG_CTRL);
    assign is_status = addr_i == HADDR_WIDTH'(ntt_regs_pkg::REG_STATUS);
    assign is_coef   = (32'(addr_i) >= ntt_regs_pkg::COEF_BASE) && (32'(addr_i) < COEF_END)
                       && (addr_i[1:0] == 2'b00);

    // Coefficients are locked while the engine owns the memory
    assign err_o   = req && (!(is_ctrl || is_status || is_coef) || (is_coef && busy_i));
    assign start_o = wr && is_ctrl && wdata_i[0] && !busy_i;

    assign mem_en_o    = req && is_coef && !busy_i;
    assign mem_we_o    = wr && is_coef && !busy_i;
    assign mem_addr_o  = addr_i[2 +: ntt_params_pkg::NTT_LOG_N];
    assign mem_wdata_o = wdata_i[ntt_params_pkg::COEF_W-1:0];
    // A CTRL write hands its mode to the engine in the same cycle as start
    assign mode_o      = (wr && is_ctrl) ? ntt_regs_pkg::ntt_mode_e'(wdata_i[1]) : mode_q;

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            mode_q <= ntt_regs_pkg::MODE_CT;
            rsel_q <= SEL_NONE;
        end else begin
            if (wr && is_ctrl) begin
                mode_q <= ntt_regs_pkg::ntt_mode_e'(wdata_i[1]);
            end
            // Read source follows the request by one cycle, like the memory
            if (kind_i == ntt_regs_pkg::KIND_READ && !err_o) begin
                if (is_ctrl) begin
                    rsel_q <= SEL_CTRL;
                end else if (is_status) begin
                    rsel_q <= SEL_STATUS;
                end else begin
                    rsel_q <= SEL_COEF;
                end
            end else begin
                rsel_q <= SEL_NONE;
            end
        end
    end

    always_comb begin
        case (rsel_q)
            SEL_CTRL:   rdata_o = HDATA_WIDTH'({mode_q, 1'b0});
            SEL_STATUS: rdata_o = HDATA_WIDTH'({done_i, busy_i});
            SEL_COEF:   rdata_o = HDATA_WIDTH'(mem_rdata_i);
            default:    rdata_o = '0;
        endcase
    end

endmodule

/* src/ntt_bus_slave.sv */
//============================
// AHB-lite slave
// One request per transfer, read wait state, two-cycle error
//============================
`timescale 1ns/1ps

module ntt_bus_slave #(
    parameter int HADDR_WIDTH = 8,
    parameter int HDATA_WIDTH = 32
) (
    input  logic                       hclk,
    input  logic                       reset_i,
    input  logic [HADDR_WIDTH-1:0]     haddr_i,
    input  logic [HDATA_WIDTH-1:0]     hwdata_i,
    input  logic                       hsel_i,
    input  logic                       hwrite_i,
    input  logic                       hready_i,
    input  logic [1:0]                 htrans_i,
    input  logic [HDATA_WIDTH-1:0]     rdata_i,
    input  logic                       err_i,
    output logic [HDATA_WIDTH-1:0]     hrdata_o,
    output logic                       hreadyout_o,
    output logic                       hresp_o,
    output ntt_regs_pkg::bus_kind_e    kind_o,
    output logic [HADDR_WIDTH-1:0]     addr_o,
    output logic [HDATA_WIDTH-1:0]     wdata_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_RD_WAIT, ST_ERR1, ST_ERR2} slv_state_e;

    slv_state_e              state_q;
    slv_state_e              resp_state;
    ntt_regs_pkg::bus_kind_e kind_q;
    logic [HADDR_WIDTH-1:0]  addr_q;
    logic                    accept;

    // NONSEQ and SEQ both have htrans[1] set
    assign accept = hsel_i && htrans_i[1] && hready_i;

    // An error flagged by the adapter turns the request cycle into the first error cycle
    always_comb begin
        resp_state = state_q;
        if (kind_q != ntt_regs_pkg::KIND_IDLE && err_i) begin
            resp_state = ST_ERR1;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            kind_q  <= ntt_regs_pkg::KIND_IDLE;
        end else begin
            if (resp_state == ST_ERR1) begin
                state_q <= ST_ERR2;
            end else if (accept && !hwrite_i) begin
                state_q <= ST_RD_WAIT;
            end else begin
                state_q <= ST_IDLE;
            end
            if (accept) begin
                kind_q <= hwrite_i ? ntt_regs_pkg::KIND_WRITE : ntt_regs_pkg::KIND_READ;
            end else begin
                kind_q <= ntt_regs_pkg::KIND_IDLE;
            end
        end
    end

    // Address phase capture
    always_ff @(posedge hclk) begin
        if (accept) begin
            addr_q <= haddr_i;
        end
    end

    assign kind_o      = kind_q;
    assign addr_o      = addr_q;
    // Write data arrives in the data phase, same cycle as the request
    assign wdata_o     = hwdata_i;
    assign hrdata_o    = rdata_i;
    assign hreadyout_o = !(resp_state inside {ST_RD_WAIT, ST_ERR1});
    assign hresp_o     = resp_state inside {ST_ERR1, ST_ERR2};

    // Error response is always the two-cycle pair
    a_err_second: assert property (@(posedge hclk) disable iff (reset_i)
        hresp_o && !hreadyout_o |=> hresp_o && hreadyout_o);
    a_err_first: assert property (@(posedge hclk) disable iff (reset_i)
        hresp_o && hreadyout_o |-> $past(hresp_o && !hreadyout_o));

endmodule

/* src/ntt_butterfly.sv */
//============================
// Modular butterfly, two stages
// CT for forward, GS for inverse
//============================
`timescale 1ns/1ps

module ntt_butterfly (
    input  logic                    hclk,
    input  logic                    reset_i,
    input  logic                    valid_i,
    input  ntt_regs_pkg::ntt_mode_e mode_i,
    input  ntt_params_pkg::coef_t   a_i,
    input  ntt_params_pkg::coef_t   b_i,
    input  ntt_params_pkg::coef_t   w_i,
    output logic                    valid_o,
    output ntt_params_pkg::coef_t   a_o,
    output ntt_params_pkg::coef_t   b_o
);

    localparam int Q = ntt_params_pkg::NTT_Q;

    typedef ntt_params_pkg::coef_t coef_t;

    // Single conditional subtraction, operands are expected below q
    function automatic coef_t add_mod(coef_t x, coef_t y);
        int unsigned s;
        s = 32'(x) + 32'(y);
        return coef_t'((s >= Q) ? s - Q : s);
    endfunction

    function automatic coef_t sub_mod(coef_t x, coef_t y);
        int unsigned d;
        d = 32'(x) + Q - 32'(y);
        return coef_t'((d >= Q) ? d - Q : d);
    endfunction

    function automatic coef_t mul_mod(coef_t x, coef_t y);
        return coef_t'((32'(x) * 32'(y)) % Q);
    endfunction

    logic                    v1_q;
    ntt_regs_pkg::ntt_mode_e mode1_q;
    coef_t                   x1_q, y1_q, w1_q;

    // Stage 1: CT reduces the product, GS forms sum and difference
    always_ff @(posedge hclk) begin
        if (mode_i == ntt_regs_pkg::MODE_CT) begin
            x1_q <= a_i;
            y1_q <= mul_mod(w_i, b_i);
        end else begin
            x1_q <= add_mod(a_i, b_i);
            y1_q <= sub_mod(a_i, b_i);
        end
        w1_q    <= w_i;
        mode1_q <= mode_i;
    end

    // Stage 2: the remaining half of each butterfly
    always_ff @(posedge hclk) begin
        if (mode1_q == ntt_regs_pkg::MODE_CT) begin
            a_o <= add_mod(x1_q, y1_q);
            b_o <= sub_mod(x1_q, y1_q);
        end else begin
            a_o <= x1_q;
            b_o <= mul_mod(y1_q, w1_q);
        end
    end

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            v1_q    <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            v1_q    <= valid_i;
            valid_o <= v1_q;
        end
    end

    a_reduced: assert property (@(posedge hclk) disable iff (reset_i)
        valid_o |-> (a_o < coef_t'(Q)) && (b_o < coef_t'(Q)));

endmodule

/* src/ntt_coef_mem.sv */
//============================
// Coefficient memory
// Bus port and engine read/write port
//============================
`timescale 1ns/1ps

module ntt_coef_mem (
    input  logic                      hclk,
    input  logic                      reset_i,
    input  logic                      bus_en_i,
    input  logic                      bus_we_i,
    input  ntt_params_pkg::coef_idx_t bus_addr_i,
    input  ntt_params_pkg::coef_t     bus_wdata_i,
    output ntt_params_pkg::coef_t     bus_rdata_o,
    ntt_mem_if.mem_mp                 mem
);

    ntt_params_pkg::coef_t coef_q [ntt_params_pkg::NTT_N];

    // Writes from either port
    always_ff @(posedge hclk) begin
        if (bus_en_i && bus_we_i) begin
            coef_q[bus_addr_i] <= bus_wdata_i;
        end
        if (mem.wr_en) begin
            coef_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Registered reads, one cycle latency
    always_ff @(posedge hclk) begin
        if (bus_en_i && !bus_we_i) begin
            bus_rdata_o <= coef_q[bus_addr_i];
        end
        if (mem.rd_en) begin
            mem.rd_data <= coef_q[mem.rd_addr];
        end
    end

    // Adapter keeps the bus out while the engine runs
    a_no_dual_write: assert property (@(posedge hclk) disable iff (reset_i)
        !(bus_en_i && bus_we_i && mem.wr_en));

endmodule

/* src/ntt_ctrl.sv */
//============================
// NTT sequencer
// Walks stages and pairs, feeds the butterfly, writes results back
//============================
`timescale 1ns/1ps

module ntt_ctrl (
    input  logic                      hclk,
    input  logic                      reset_i,
    input  logic                      start_i,
    input  ntt_regs_pkg::ntt_mode_e   mode_i,
    output logic                      busy_o,
    output logic                      done_o,
    ntt_mem_if.ctrl_mp                mem,
    output logic                      bf_valid_o,
    output ntt_regs_pkg::ntt_mode_e   bf_mode_o,
    output ntt_params_pkg::coef_t     bf_a_o,
    output ntt_params_pkg::coef_t     bf_b_o,
    output ntt_params_pkg::coef_t     bf_w_o,
    input  logic                      bf_valid_i,
    input  ntt_params_pkg::coef_t     bf_a_i,
    input  ntt_params_pkg::coef_t     bf_b_i
);

    typedef ntt_params_pkg::coef_idx_t idx_t;
    typedef enum logic [2:0] {ST_IDLE, ST_RD_A, ST_RD_B, ST_ISSUE, ST_DRAIN} ctrl_state_e;

    ctrl_state_e             state_q;
    ntt_regs_pkg::ntt_mode_e mode_q;
    logic                    fwd;
    idx_t                    len_q, j_q, k_q;
    logic                    grp_end, stage_end, last_stage;
    ntt_params_pkg::coef_t   a_q;

    // Write queue of pending pair bases, b address is base + len
    idx_t                    q_mem [2];
    logic                    q_wp, q_rp;
    logic [1:0]              q_cnt;
    logic                    wb_pend_q;
    idx_t                    wb_addr_q;
    ntt_params_pkg::coef_t   wb_data_q;

    assign fwd        = mode_q == ntt_regs_pkg::MODE_CT;
    assign grp_end    = (j_q & (len_q - idx_t'(1))) == (len_q - idx_t'(1));
    assign stage_end  = (j_q + len_q) == idx_t'(ntt_params_pkg::NTT_N - 1);
    assign last_stage = fwd ? (len_q == idx_t'(1)) : (len_q == idx_t'(8));

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b0;
            mode_q  <= ntt_regs_pkg::MODE_CT;
            len_q   <= '0;
            j_q     <= '0;
            k_q     <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (start_i) begin
                    mode_q  <= mode_i;
                    done_o  <= 1'b0;
                    len_q   <= (mode_i == ntt_regs_pkg::MODE_CT) ? idx_t'(8) : idx_t'(1);
                    k_q     <= (mode_i == ntt_regs_pkg::MODE_CT) ? idx_t'(1) : idx_t'(15);
                    j_q     <= '0;
                    state_q <= ST_RD_A;
                end
                ST_RD_A: state_q <= ST_RD_B;
                ST_RD_B: state_q <= ST_ISSUE;
                ST_ISSUE: begin
                    j_q     <= grp_end ? j_q + len_q + idx_t'(1) : j_q + idx_t'(1);
                    if (grp_end) begin
                        k_q <= fwd ? k_q + idx_t'(1) : k_q - idx_t'(1);
                    end
                    state_q <= stage_end ? ST_DRAIN : ST_RD_A;
                end
                ST_DRAIN: if (q_cnt == 2'd0 && !wb_pend_q) begin
                    // Next stage reads only after every write has landed
                    if (last_stage) begin
                        done_o  <= 1'b1;
                        state_q <= ST_IDLE;
                    end else begin
                        len_q   <= fwd ? len_q >> 1 : len_q << 1;
                        j_q     <= '0;
                        state_q <= ST_RD_A;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o = state_q != ST_IDLE;

    // Read a, then b, then hand both to the butterfly
    assign mem.rd_en   = state_q inside {ST_RD_A, ST_RD_B};
    assign mem.rd_addr = (state_q == ST_RD_A) ? j_q : j_q + len_q;

    always_ff @(posedge hclk) begin
        if (state_q == ST_RD_B) begin
            a_q <= mem.rd_data;
        end
    end

    assign bf_valid_o = state_q == ST_ISSUE;
    assign bf_mode_o  = mode_q;
    assign bf_a_o     = a_q;
    assign bf_b_o     = mem.rd_data;
    assign bf_w_o     = fwd ? ntt_params_pkg::NTT_TWIDDLE[k_q]
                            : ntt_params_pkg::coef_t'(ntt_params_pkg::NTT_Q)
                              - ntt_params_pkg::NTT_TWIDDLE[k_q];

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            q_wp      <= 1'b0;
            q_rp      <= 1'b0;
            q_cnt     <= 2'd0;
            wb_pend_q <= 1'b0;
        end else begin
            if (bf_valid_o) begin
                q_wp <= ~q_wp;
            end
            if (bf_valid_i) begin
                q_rp <= ~q_rp;
            end
            q_cnt     <= q_cnt + {1'b0, bf_valid_o} - {1'b0, bf_valid_i};
            wb_pend_q <= bf_valid_i;
        end
    end

    always_ff @(posedge hclk) begin
        if (bf_valid_o) begin
            q_mem[q_wp] <= j_q;
        end
        if (bf_valid_i) begin
            wb_addr_q <= q_mem[q_rp] + len_q;
            wb_data_q <= bf_b_i;
        end
    end

    // a' goes out with the result, b' one cycle later
    assign mem.wr_en   = bf_valid_i || wb_pend_q;
    assign mem.wr_addr = bf_valid_i ? q_mem[q_rp] : wb_addr_q;
    assign mem.wr_data = bf_valid_i ? bf_a_i : wb_data_q;

    // Every butterfly result must find a queued destination
    a_queue_match: assert property (@(posedge hclk) disable iff (reset_i)
        bf_valid_i |-> (q_cnt != 2'd0) && !wb_pend_q);

endmodule

/* src/ntt_mem_if.sv */
//============================
// Engine side of the coefficient memory
//============================
`timescale 1ns/1ps

interface ntt_mem_if;

    logic                      rd_en;
    ntt_params_pkg::coef_idx_t rd_addr;
    ntt_params_pkg::coef_t     rd_data;
    logic                      wr_en;
    ntt_params_pkg::coef_idx_t wr_addr;
    ntt_params_pkg::coef_t     wr_data;

    modport ctrl_mp (output rd_en, rd_addr, wr_en, wr_addr, wr_data, input rd_data);
    modport mem_mp  (input rd_en, rd_addr, wr_en, wr_addr, wr_data, output rd_data);

endinterface

/* src/ntt_params_pkg.sv */
//============================
// NTT arithmetic parameters
// Modulus, sizes and the bit-reversed twiddle table
//============================
package ntt_params_pkg;

    localparam int NTT_Q     = 257;
    localparam int NTT_N     = 16;
    localparam int NTT_LOG_N = 4;
    localparam int COEF_W    = 9;
    // Primitive 32nd root of unity mod q
    localparam int NTT_ZETA  = 136;

    typedef logic [COEF_W-1:0]    coef_t;
    typedef logic [NTT_LOG_N-1:0] coef_idx_t;
    typedef coef_t                twiddle_t [NTT_N];

    // Entry k is zeta to the power bitrev(k)
    function automatic twiddle_t gen_twiddle();
        twiddle_t    tab;
        int unsigned rev;
        int unsigned pw;
        for (int k = 0; k < NTT_N; k++) begin
            rev = 0;
            for (int b = 0; b < NTT_LOG_N; b++) begin
                rev |= ((k >> b) & 1) << (NTT_LOG_N - 1 - b);
            end
            pw = 1;
            repeat (rev) pw = (pw * NTT_ZETA) % NTT_Q;
            tab[k] = coef_t'(pw);
        end
        return tab;
    endfunction

    localparam twiddle_t NTT_TWIDDLE = gen_twiddle();

endpackage

/* src/ntt_regs_pkg.sv */
//============================
// NTT register map
// Byte addresses, modes and bus request kinds
//============================
package ntt_regs_pkg;

    // Transform direction, bit 1 of CTRL
    typedef enum logic {
        MODE_CT = 1'b0,
        MODE_GS = 1'b1
    } ntt_mode_e;

    // Request issued by the bus slave in the data phase
    typedef enum logic [1:0] {
        KIND_IDLE  = 2'd0,
        KIND_READ  = 2'd1,
        KIND_WRITE = 2'd2
    } bus_kind_e;

    // CTRL: bit 0 start, bit 1 mode
    localparam int unsigned REG_CTRL   = 32'h00;
    // STATUS: bit 0 busy, bit 1 done (sticky)
    localparam int unsigned REG_STATUS = 32'h04;
    // Coefficient i lives at COEF_BASE + 4*i
    localparam int unsigned COEF_BASE  = 32'h40;

endpackage

/* src/ntt_wrapper_top.sv */
//============================
// NTT test wrapper top level
// AHB-lite slave, adapter, memory and transform engine
//============================
`timescale 1ns/1ps

module ntt_wrapper_top #(
    parameter int HADDR_WIDTH = 8,
    parameter int HDATA_WIDTH = 32
) (
    input  logic                   hclk,
    input  logic                   reset_i,
    input  logic [HADDR_WIDTH-1:0] haddr_i,
    input  logic [HDATA_WIDTH-1:0] hwdata_i,
    input  logic                   hsel_i,
    input  logic                   hwrite_i,
    input  logic                   hready_i,
    input  logic [1:0]             htrans_i,
    output logic [HDATA_WIDTH-1:0] hrdata_o,
    output logic                   hreadyout_o,
    output logic                   hresp_o
);

    // Slave to adapter
    ntt_regs_pkg::bus_kind_e   kind;
    logic [HADDR_WIDTH-1:0]    addr;
    logic [HDATA_WIDTH-1:0]    wdata, rdata;
    logic                      err;

    // Adapter to memory and engine
    logic                      start, busy, done;
    ntt_regs_pkg::ntt_mode_e   mode;
    logic                      mem_en, mem_we;
    ntt_params_pkg::coef_idx_t mem_addr;
    ntt_params_pkg::coef_t     mem_wdata, mem_rdata;

    // Sequencer to butterfly
    logic                      bf_in_valid, bf_out_valid;
    ntt_regs_pkg::ntt_mode_e   bf_mode;
    ntt_params_pkg::coef_t     bf_a, bf_b, bf_w, bf_a_res, bf_b_res;

    ntt_mem_if u_mem_if ();

    ntt_bus_slave #(.HADDR_WIDTH(HADDR_WIDTH), .HDATA_WIDTH(HDATA_WIDTH)) u_slave (
        .hclk(hclk), .reset_i(reset_i), .haddr_i(haddr_i), .hwdata_i(hwdata_i),
        .hsel_i(hsel_i), .hwrite_i(hwrite_i), .hready_i(hready_i), .htrans_i(htrans_i),
        .rdata_i(rdata), .err_i(err), .hrdata_o(hrdata_o), .hreadyout_o(hreadyout_o),
        .hresp_o(hresp_o), .kind_o(kind), .addr_o(addr), .wdata_o(wdata)
    );

    ntt_bus_adapter #(.HADDR_WIDTH(HADDR_WIDTH), .HDATA_WIDTH(HDATA_WIDTH)) u_adapter (
        .hclk(hclk), .reset_i(reset_i), .kind_i(kind), .addr_i(addr), .wdata_i(wdata),
        .busy_i(busy), .done_i(done), .rdata_o(rdata), .err_o(err), .start_o(start),
        .mode_o(mode), .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
    );

    ntt_coef_mem u_mem (
        .hclk(hclk), .reset_i(reset_i), .bus_en_i(mem_en), .bus_we_i(mem_we),
        .bus_addr_i(mem_addr), .bus_wdata_i(mem_wdata), .bus_rdata_o(mem_rdata),
        .mem(u_mem_if.mem_mp)
    );

    ntt_ctrl u_ctrl (
        .hclk(hclk), .reset_i(reset_i), .start_i(start), .mode_i(mode), .busy_o(busy),
        .done_o(done), .mem(u_mem_if.ctrl_mp), .bf_valid_o(bf_in_valid), .bf_mode_o(bf_mode),
        .bf_a_o(bf_a), .bf_b_o(bf_b), .bf_w_o(bf_w), .bf_valid_i(bf_out_valid),
        .bf_a_i(bf_a_res), .bf_b_i(bf_b_res)
    );

    ntt_butterfly u_butterfly (
        .hclk(hclk), .reset_i(reset_i), .valid_i(bf_in_valid), .mode_i(bf_mode),
        .a_i(bf_a), .b_i(bf_b), .w_i(bf_w), .valid_o(bf_out_valid),
        .a_o(bf_a_res), .b_o(bf_b_res)
    );

endmodule
